//--- logic/rv_core_if.sv
//------------------------------------------------
// Links between the core units
// exec_if has no ready, one instruction in flight
//------------------------------------------------
`timescale 1ns/1ps

// Register file read ports, data returns combinationally
interface rf_read_if;
    import rv_core_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    modport requester (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport responder (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface : rf_read_if

// Decoded instruction from decode to execute
interface exec_if;
    import rv_core_pkg::*;

    logic                  valid;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  is_load;
    logic                  is_store;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wr_en;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       store_data;

    modport source (output valid, alu_op, is_load, is_store, rd, wr_en, op_a, op_b,
                    store_data);
    modport sink   (input  valid, alu_op, is_load, is_store, rd, wr_en, op_a, op_b,
                    store_data);
endinterface : exec_if

// Write-back from execute to the result stage
interface wb_if;
    import rv_core_pkg::*;

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wr_en;
    logic [XLEN-1:0]       data;

    modport source (output valid, rd, wr_en, data);
    modport sink   (input  valid, rd, wr_en, data);
endinterface : wb_if

//--- logic/rv_core_pkg.sv
//------------------------------------------------
// Shared constants for the RV32I subset core
// Only word loads and stores, no branches or CSRs
//------------------------------------------------

package rv_core_pkg;

    localparam int XLEN       = 32;                 // Data and address width
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;

    localparam logic [XLEN-1:0] RESET_PC = '0;      // First fetch address

    //------------------------------------------------
    // Major opcodes
    //------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD   = 3'b000;       // Also ADDI and SUB
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_LW_SW = 3'b010;       // Word access width

    localparam logic [6:0] F7_SUB = 7'b0100000;

    //------------------------------------------------
    // ALU operation codes
    //------------------------------------------------
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd6;  // Operand B straight through

    // One instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic [19:0]           imm;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } instr_u;

endpackage : rv_core_pkg

//--- logic/rv_core_top.sv
//------------------------------------------------
// RV32I subset core, one instruction in flight
// Two Wishbone classic masters, word access only
//------------------------------------------------
`timescale 1ns/1ps

module rv_core_top (
    input  logic                         clk,
    input  logic                         i_rst_n,

    // Instruction memory
    output logic                         o_imem_cyc,
    output logic                         o_imem_stb,
    output logic [rv_core_pkg::XLEN-1:0] o_imem_adr,
    input  logic [rv_core_pkg::XLEN-1:0] i_imem_dat,
    input  logic                         i_imem_ack,

    // Data memory
    output logic                         o_dmem_cyc,
    output logic                         o_dmem_stb,
    output logic                         o_dmem_we,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_adr,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_dat,
    input  logic [rv_core_pkg::XLEN-1:0] i_dmem_dat,
    input  logic                         i_dmem_ack
);

    logic                         instr_valid;
    logic [rv_core_pkg::XLEN-1:0] instr;
    logic                         retire;

    rf_read_if rf_rd ();
    exec_if    ex    ();
    wb_if      wb    ();

    //------------------------------------------------
    // Pipeline units
    //------------------------------------------------
    rv_fetch u_fetch (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .i_retire      (retire     ),
        .o_imem_cyc    (o_imem_cyc ),
        .o_imem_stb    (o_imem_stb ),
        .o_imem_adr    (o_imem_adr ),
        .i_imem_dat    (i_imem_dat ),
        .i_imem_ack    (i_imem_ack ),
        .o_instr_valid (instr_valid),
        .o_instr       (instr      )
    );

    rv_decode u_decode (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .i_instr_valid (instr_valid),
        .i_instr       (instr      ),
        .rf            (rf_rd      ),
        .exec          (ex         )
    );

    rv_execute u_execute (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .exec          (ex         ),
        .wb            (wb         ),
        .o_dmem_cyc    (o_dmem_cyc ),
        .o_dmem_stb    (o_dmem_stb ),
        .o_dmem_we     (o_dmem_we  ),
        .o_dmem_adr    (o_dmem_adr ),
        .o_dmem_dat    (o_dmem_dat ),
        .i_dmem_dat    (i_dmem_dat ),
        .i_dmem_ack    (i_dmem_ack )
    );

    rv_result u_result (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .wb            (wb         ),
        .rf            (rf_rd      ),
        .o_retire      (retire     )
    );

endmodule : rv_core_top

//--- logic/rv_decode.sv
//------------------------------------------------
// Decode unit, one registered stage
// Unsupported encodings go out as no-write no-ops
//------------------------------------------------
`timescale 1ns/1ps

module rv_decode (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_instr_valid,
    input  logic [rv_core_pkg::XLEN-1:0] i_instr,
    rf_read_if.requester                 rf,
    exec_if.source                       exec
);
    import rv_core_pkg::*;

    instr_u              ins;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_d;
    logic [ALU_OP_W-1:0] alu_op_d;
    logic                use_imm;
    logic                wr_en_d;
    logic                load_d;
    logic                store_d;

    assign ins = i_instr;

    // Sign-extended immediates
    assign imm_i = {{(XLEN-12){ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{(XLEN-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign imm_u = {ins.u.imm, 12'b0};

    // Register file addresses, read in the instr_valid cycle
    assign rf.rs1_addr = ins.r.rs1;
    assign rf.rs2_addr = ins.r.rs2;    // Same position in S format

    always_comb begin
        alu_op_d = ALU_ADD;
        use_imm  = 1'b1;
        imm_d    = imm_i;
        wr_en_d  = 1'b0;
        load_d   = 1'b0;
        store_d  = 1'b0;
        case (ins.r.opcode)
            OPC_OP: begin
                use_imm = 1'b0;
                wr_en_d = 1'b1;
                case (ins.r.funct3)
                    F3_ADD:  alu_op_d = (ins.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_op_d = ALU_SLT;
                    F3_XOR:  alu_op_d = ALU_XOR;
                    F3_OR:   alu_op_d = ALU_OR;
                    F3_AND:  alu_op_d = ALU_AND;
                    default: wr_en_d  = 1'b0;    // Shifts, SLTU not built
                endcase
            end
            OPC_OP_IMM: begin
                wr_en_d = 1'b1;
                case (ins.i.funct3)
                    F3_ADD:  alu_op_d = ALU_ADD;
                    F3_XOR:  alu_op_d = ALU_XOR;
                    F3_OR:   alu_op_d = ALU_OR;
                    F3_AND:  alu_op_d = ALU_AND;
                    default: wr_en_d  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                alu_op_d = ALU_PASS_B;
                imm_d    = imm_u;
                wr_en_d  = 1'b1;
            end
            OPC_LOAD: begin
                load_d  = (ins.i.funct3 == F3_LW_SW);
                wr_en_d = load_d;
            end
            OPC_STORE: begin
                imm_d   = imm_s;
                store_d = (ins.s.funct3 == F3_LW_SW);
            end
            default: ;                           // Retires with no effect
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= i_instr_valid;
        end
    end

    // Payload, qualified by exec.valid
    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            exec.alu_op     <= alu_op_d;
            exec.is_load    <= load_d;
            exec.is_store   <= store_d;
            exec.rd         <= ins.r.rd;
            exec.wr_en      <= wr_en_d;
            exec.op_a       <= rf.rs1_data;
            exec.op_b       <= use_imm ? imm_d : rf.rs2_data;
            exec.store_data <= rf.rs2_data;
        end
    end

endmodule : rv_decode

//--- logic/rv_execute.sv
//------------------------------------------------
// Execute unit, ALU and Wishbone master on dmem
// Word accesses only, address is the ALU sum
//------------------------------------------------
`timescale 1ns/1ps

module rv_execute (
    input  logic                         clk,
    input  logic                         i_rst_n,
    exec_if.sink                         exec,
    wb_if.source                         wb,

    // Data memory, Wishbone classic
    output logic                         o_dmem_cyc,
    output logic                         o_dmem_stb,
    output logic                         o_dmem_we,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_adr,
    output logic [rv_core_pkg::XLEN-1:0] o_dmem_dat,
    input  logic [rv_core_pkg::XLEN-1:0] i_dmem_dat,
    input  logic                         i_dmem_ack
);
    import rv_core_pkg::*;

    logic            mem_q;      // Data cycle in progress
    logic            we_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] dat_q;
    logic [XLEN-1:0] alu_res;
    logic            is_mem;

    //------------------------------------------------
    // ALU
    //------------------------------------------------
    always_comb begin
        case (exec.alu_op)
            ALU_ADD:    alu_res = exec.op_a + exec.op_b;
            ALU_SUB:    alu_res = exec.op_a - exec.op_b;
            ALU_AND:    alu_res = exec.op_a & exec.op_b;
            ALU_OR:     alu_res = exec.op_a | exec.op_b;
            ALU_XOR:    alu_res = exec.op_a ^ exec.op_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}},
                                   $signed(exec.op_a) < $signed(exec.op_b)};
            ALU_PASS_B: alu_res = exec.op_b;
            default:    alu_res = '0;
        endcase
    end

    assign is_mem = exec.is_load | exec.is_store;

    //------------------------------------------------
    // Control, one data cycle per load or store
    //------------------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_q    <= 1'b0;
            we_q     <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= 1'b0;
            if (mem_q) begin
                if (i_dmem_ack) begin
                    mem_q    <= 1'b0;
                    wb.valid <= 1'b1;     // Retire the cycle after ack
                end
            end else if (exec.valid) begin
                mem_q    <= is_mem;
                we_q     <= exec.is_store;
                wb.valid <= ~is_mem;      // ALU result in one cycle
            end
        end
    end

    // Bus payload and write-back data
    always_ff @(posedge clk) begin
        if (!mem_q && exec.valid) begin
            adr_q    <= alu_res;
            dat_q    <= exec.store_data;
            wb.rd    <= exec.rd;
            wb.wr_en <= exec.wr_en;       // Low for stores
            wb.data  <= alu_res;
        end else if (mem_q && i_dmem_ack) begin
            wb.data  <= i_dmem_dat;       // Load data sampled on ack
        end
    end

    assign o_dmem_cyc = mem_q;
    assign o_dmem_stb = mem_q;
    assign o_dmem_we  = mem_q & we_q;
    assign o_dmem_adr = adr_q;
    assign o_dmem_dat = dat_q;

endmodule : rv_execute

//--- logic/rv_fetch.sv
//------------------------------------------------
// Fetch unit, Wishbone classic master on imem
// Next fetch starts only after retire, PC + 4
//------------------------------------------------
`timescale 1ns/1ps

module rv_fetch (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_retire,

    // Instruction memory, Wishbone classic
    output logic                         o_imem_cyc,
    output logic                         o_imem_stb,
    output logic [rv_core_pkg::XLEN-1:0] o_imem_adr,
    input  logic [rv_core_pkg::XLEN-1:0] i_imem_dat,
    input  logic                         i_imem_ack,

    // To decode
    output logic                         o_instr_valid,
    output logic [rv_core_pkg::XLEN-1:0] o_instr
);
    import rv_core_pkg::*;

    logic            fetch_q;        // 1 fetching, 0 waiting for retire
    logic            boot_q;         // First fetch after reset pending
    logic [XLEN-1:0] pc_q;
    logic            instr_valid_q;
    logic [XLEN-1:0] instr_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fetch_q       <= 1'b0;
            boot_q        <= 1'b1;
            pc_q          <= RESET_PC;
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= 1'b0;
            if (fetch_q) begin
                if (i_imem_ack) begin
                    fetch_q       <= 1'b0;
                    instr_valid_q <= 1'b1;   // Pulse in the cycle after ack
                end
            end else if (boot_q || i_retire) begin
                fetch_q <= 1'b1;
                boot_q  <= 1'b0;
                if (i_retire) begin
                    pc_q <= pc_q + XLEN'(4); // No branches, always sequential
                end
            end
        end
    end

    // Instruction word sampled in the ack cycle
    always_ff @(posedge clk) begin
        if (fetch_q && i_imem_ack) begin
            instr_q <= i_imem_dat;
        end
    end

    assign o_imem_cyc    = fetch_q;
    assign o_imem_stb    = fetch_q;
    assign o_imem_adr    = pc_q;        // Held until ack
    assign o_instr_valid = instr_valid_q;
    assign o_instr       = instr_q;

endmodule : rv_fetch

//--- logic/rv_result.sv
//------------------------------------------------
// Result stage, register file and write-back
// x0 is never written and reads as zero
//------------------------------------------------
`timescale 1ns/1ps

module rv_result (
    input  logic clk,
    input  logic i_rst_n,
    wb_if.sink   wb,
    rf_read_if.responder rf,
    output logic o_retire
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [REG_NUM-1:1];   // x1 to x31

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int n = 1; n < REG_NUM; n++) begin
                regs[n] <= '0;
            end
        end else if (wb.valid && wb.wr_en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Asynchronous read ports for decode
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    assign o_retire = wb.valid;            // Same cycle as the write

endmodule : rv_result

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rv_core_tb -f rv_core.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_core_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^Done: no errors$'; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi

//--- rv_core.f
logic/rv_core_pkg.sv
logic/rv_core_if.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core_top.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

//--- verification/rv_core_properties.sv
//------------------------------------------------
// Wishbone classic protocol assertions, bound
// to rv_core_top, idle while reset is low
//------------------------------------------------
`timescale 1ns/1ps

module rv_core_properties (
    input logic                         clk,
    input logic                         i_rst_n,
    input logic                         i_imem_cyc,
    input logic                         i_imem_stb,
    input logic [rv_core_pkg::XLEN-1:0] i_imem_adr,
    input logic                         i_imem_ack,
    input logic                         i_dmem_cyc,
    input logic                         i_dmem_stb,
    input logic                         i_dmem_we,
    input logic [rv_core_pkg::XLEN-1:0] i_dmem_adr,
    input logic [rv_core_pkg::XLEN-1:0] i_dmem_dat,
    input logic                         i_dmem_ack
);
    import rv_core_pkg::*;

    stb_in_cyc: assert property (@(posedge clk) disable iff (!i_rst_n)
        (!i_imem_stb || i_imem_cyc) && (!i_dmem_stb || i_dmem_cyc))
        else $error("Strobe high outside a bus cycle");

    // Request held until acknowledged
    imem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_imem_stb && !i_imem_ack) |=> (i_imem_stb && $stable(i_imem_adr)))
        else $error("Instruction request changed before ack");

    dmem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_dmem_stb && !i_dmem_ack) |=> (i_dmem_stb && $stable(i_dmem_adr)
                                         && $stable(i_dmem_dat) && $stable(i_dmem_we)))
        else $error("Data request changed before ack");

    one_cycle_active: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_imem_cyc && i_dmem_cyc))
        else $error("Instruction and data cycles overlap");

endmodule : rv_core_properties

bind rv_core_top rv_core_properties u_props (
    .clk        (clk       ),
    .i_rst_n    (i_rst_n   ),
    .i_imem_cyc (o_imem_cyc),
    .i_imem_stb (o_imem_stb),
    .i_imem_adr (o_imem_adr),
    .i_imem_ack (i_imem_ack),
    .i_dmem_cyc (o_dmem_cyc),
    .i_dmem_stb (o_dmem_stb),
    .i_dmem_we  (o_dmem_we ),
    .i_dmem_adr (o_dmem_adr),
    .i_dmem_dat (o_dmem_dat),
    .i_dmem_ack (i_dmem_ack)
);

//--- verification/rv_core_tb.sv
//------------------------------------------------
// Testbench for rv_core_top, random program run
// Checks every data write against a model core
// Memory acks come after 0 to 3 cycles
//------------------------------------------------
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int              NUM_INSTR      = 200;
    localparam int              PROG_WORDS     = 512;
    localparam int              DELAY_WORDS    = 1024;
    localparam int              TIMEOUT_CYCLES = 20000;
    localparam logic [XLEN-1:0] FILL_KEY       = 32'hc3a5_96e1;

    logic            clk;
    logic            rst_n;
    logic            imem_cyc;
    logic            imem_stb;
    logic [XLEN-1:0] imem_adr;
    logic [XLEN-1:0] imem_dat = '0;
    logic            imem_ack = 1'b0;
    logic            dmem_cyc;
    logic            dmem_stb;
    logic            dmem_we;
    logic [XLEN-1:0] dmem_adr;
    logic [XLEN-1:0] dmem_wdat;
    logic [XLEN-1:0] dmem_dat = '0;
    logic            dmem_ack = 1'b0;

    integer          seed = 32'he37d_4930;
    logic [XLEN-1:0] prog      [0:PROG_WORDS-1];
    int              delay_tab [0:DELAY_WORDS-1];
    logic [XLEN-1:0] dmem      [0:63];
    bit              dmem_written [0:63];
    logic [XLEN-1:0] ref_mem   [0:63];
    logic [XLEN-1:0] ref_regs  [0:REG_NUM-1];
    logic [XLEN-1:0] exp_adr   [$];
    logic [XLEN-1:0] exp_dat   [$];
    int              exp_total;
    int              stores_seen = 0;
    logic [XLEN-1:0] fetch_pc = RESET_PC;
    int              imem_wait;
    int              imem_ptr = 0;
    bit              imem_busy = 1'b0;
    int              dmem_wait;
    int              dmem_ptr = 1;
    bit              dmem_busy = 1'b0;
    int              cycles;

    rv_core_top uut (
        .clk        (clk      ),
        .i_rst_n    (rst_n    ),
        .o_imem_cyc (imem_cyc ),
        .o_imem_stb (imem_stb ),
        .o_imem_adr (imem_adr ),
        .i_imem_dat (imem_dat ),
        .i_imem_ack (imem_ack ),
        .o_dmem_cyc (dmem_cyc ),
        .o_dmem_stb (dmem_stb ),
        .o_dmem_we  (dmem_we  ),
        .o_dmem_adr (dmem_adr ),
        .o_dmem_dat (dmem_wdat),
        .i_dmem_dat (dmem_dat ),
        .i_dmem_ack (dmem_ack )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    //------------------------------------------------
    // Helpers and reference model
    //------------------------------------------------
    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return XLEN'(idx * 4) ^ FILL_KEY;   // Whole byte address
    endfunction

    function automatic logic [XLEN-1:0] store_instr(input logic [4:0] src,
                                                    input logic [5:0] word_idx);
        instr_u ins;
        ins          = '0;                  // Base register x0
        ins.s.opcode = OPC_STORE;
        ins.s.funct3 = F3_LW_SW;
        ins.s.rs2    = src;
        ins.s.imm_hi = {4'b0, word_idx[5:3]};
        ins.s.imm_lo = {word_idx[2:0], 2'b00};
        return ins;
    endfunction

    function automatic logic [XLEN-1:0] random_instr();
        instr_u     ins;
        int         kind;
        int         sel;
        logic [2:0] f3;
        kind = int'({$random(seed)} % 14);
        ins  = $random(seed);               // Random registers and immediates
        sel  = (kind < 6) ? kind : kind - 5;
        case (sel)
            0, 1:    f3 = F3_ADD;
            2:       f3 = F3_AND;
            3:       f3 = F3_OR;
            4:       f3 = F3_XOR;
            default: f3 = F3_SLT;
        endcase
        if (kind < 6) begin
            ins.r.opcode = OPC_OP;
            ins.r.funct3 = f3;
            ins.r.funct7 = (kind == 1) ? F7_SUB : 7'h00;
        end else if (kind < 10) begin
            ins.i.opcode = OPC_OP_IMM;
            ins.i.funct3 = f3;
        end else if (kind == 10) begin
            ins.u.opcode = OPC_LUI;
        end else if (kind == 11) begin
            ins.i.opcode = OPC_LOAD;
            ins.i.funct3 = F3_LW_SW;
            ins.i.rs1    = '0;
            ins.i.imm    = {4'b0, 6'($random(seed)), 2'b00};
        end else if (kind == 12) begin
            ins = store_instr(ins.s.rs2, 6'($random(seed)));
        end else begin
            ins.r.opcode = 7'b0001011;      // Custom opcode, not executed
        end
        return ins;
    endfunction

    // Returns 1 for a store, with its address and data
    function automatic bit rv_ref_step(input logic [XLEN-1:0] word,
                                       output logic [XLEN-1:0] st_adr,
                                       output logic [XLEN-1:0] st_dat);
        instr_u          ins;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] mem_adr;
        logic [XLEN-1:0] res;
        bit              wr;
        bit              st;
        ins     = word;
        rs1_val = ref_regs[ins.r.rs1];
        rs2_val = ref_regs[ins.r.rs2];
        imm     = {{20{ins.i.imm[11]}}, ins.i.imm};
        res     = '0;
        wr      = 1'b1;
        st      = 1'b0;
        st_adr  = '0;
        st_dat  = '0;
        case (ins.r.opcode)
            OPC_OP: begin
                case ({ins.r.funct7, ins.r.funct3})
                    {7'h00, F3_ADD}:  res = rs1_val + rs2_val;
                    {F7_SUB, F3_ADD}: res = rs1_val - rs2_val;
                    {7'h00, F3_AND}:  res = rs1_val & rs2_val;
                    {7'h00, F3_OR}:   res = rs1_val | rs2_val;
                    {7'h00, F3_XOR}:  res = rs1_val ^ rs2_val;
                    {7'h00, F3_SLT}:  res = ($signed(rs1_val) < $signed(rs2_val)) ? 1 : 0;
                    default:          wr  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                case (ins.i.funct3)
                    F3_ADD:  res = rs1_val + imm;
                    F3_AND:  res = rs1_val & imm;
                    F3_OR:   res = rs1_val | imm;
                    F3_XOR:  res = rs1_val ^ imm;
                    default: wr  = 1'b0;
                endcase
            end
            OPC_LUI:  res = {ins.u.imm, 12'h000};
            OPC_LOAD: begin
                mem_adr = rs1_val + imm;
                res     = ref_mem[mem_adr[7:2]];
            end
            OPC_STORE: begin
                wr     = 1'b0;
                st     = 1'b1;
                imm    = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                st_adr = rs1_val + imm;
                st_dat = rs2_val;
                ref_mem[st_adr[7:2]] = rs2_val;
            end
            default:  wr = 1'b0;            // Unknown opcode is a no-op
        endcase
        if (wr && ins.r.rd != 0) begin
            ref_regs[ins.r.rd] = res;
        end
        return st;
    endfunction

    task automatic build_program();
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        int              n;
        n = 0;
        for (int k = 0; k < PROG_WORDS; k++) begin
            prog[k] = '0;                   // Past the end runs as no-ops
        end
        for (int k = 0; k < NUM_INSTR; k++) begin
            prog[n] = random_instr();
            n++;
            if (k % 3 == 2) begin
                prog[n] = store_instr(5'($random(seed)), 6'($random(seed)));
                n++;
            end
        end
        for (int k = 0; k < DELAY_WORDS; k++) begin
            delay_tab[k] = int'({$random(seed)} % 4);
        end
        for (int k = 0; k < REG_NUM; k++) begin
            ref_regs[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            ref_mem[k] = fill_word(k);
        end
        for (int k = 0; k < n; k++) begin
            if (rv_ref_step(prog[k], adr, dat)) begin
                exp_adr.push_back(adr);
                exp_dat.push_back(dat);
            end
        end
        exp_total = exp_adr.size();
    endtask

    //------------------------------------------------
    // Memory models, driven on the falling edge
    //------------------------------------------------
    always @(negedge clk) begin
        if (imem_ack) begin
            imem_ack  <= 1'b0;
            imem_busy = 1'b0;
        end else if (rst_n && imem_stb) begin
            if (!imem_busy) begin
                imem_busy = 1'b1;
                imem_wait = delay_tab[imem_ptr];
                imem_ptr  = (imem_ptr + 2) % DELAY_WORDS;
            end
            if (imem_wait == 0) begin
                imem_ack <= 1'b1;
                imem_dat <= (imem_adr[31:2] < PROG_WORDS) ? prog[imem_adr[10:2]] : '0;
            end else begin
                imem_wait = imem_wait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (dmem_ack) begin
            dmem_ack  <= 1'b0;
            dmem_busy = 1'b0;
        end else if (rst_n && dmem_stb) begin
            if (!dmem_busy) begin
                dmem_busy = 1'b1;
                dmem_wait = delay_tab[dmem_ptr];
                dmem_ptr  = (dmem_ptr + 2) % DELAY_WORDS;
            end
            if (dmem_wait == 0) begin
                dmem_ack <= 1'b1;
                if (dmem_we) begin
                    dmem[dmem_adr[7:2]]         = dmem_wdat;
                    dmem_written[dmem_adr[7:2]] = 1'b1;
                end else begin
                    dmem_dat <= dmem_written[dmem_adr[7:2]] ? dmem[dmem_adr[7:2]]
                                                            : fill_word(int'(dmem_adr[7:2]));
                end
            end else begin
                dmem_wait = dmem_wait - 1;
            end
        end
    end

    // Fetch order and store contents, checked in the ack cycle
    always @(posedge clk) begin
        if (rst_n && imem_stb && imem_ack) begin
            check_value("fetch address", imem_adr, fetch_pc);
            fetch_pc <= fetch_pc + 4;
        end
        if (rst_n && dmem_stb && dmem_we && dmem_ack) begin
            if (exp_adr.size() == 0) begin
                $display("Unexpected data write to address %h at %0t", dmem_adr, $time);
                $display("Done: errors found");
                $fatal(1);
            end else begin
                check_value("store address", dmem_adr, exp_adr.pop_front());
                check_value("store data", dmem_wdat, exp_dat.pop_front());
                stores_seen <= stores_seen + 1;
            end
        end
    end

    //------------------------------------------------
    // Main sequence
    //------------------------------------------------
    initial begin
        rst_n = 1'b0;
        build_program();
        repeat (10) begin
            @(negedge clk);
            check_value("bus strobes in reset",
                        XLEN'({imem_cyc, imem_stb, dmem_cyc, dmem_stb}), '0);
        end
        rst_n  = 1'b1;
        cycles = 0;
        while (stores_seen < exp_total && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (stores_seen < exp_total) begin
            $display("Timeout: only %0d of %0d stores arrived", stores_seen, exp_total);
            $display("Done: errors found");
            $fatal(1);
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule : rv_core_tb
